// ==== verilog/cache_pkg.sv ====
package cache_pkg;

    ////////////////////////////////////////
    // Geometry
    ////////////////////////////////////////

    localparam int addr_width     = 32;    // Byte address
    localparam int word_width     = 32;
    localparam int word_bytes     = word_width / 8;
    localparam int words_per_line = 4;
    localparam int line_width     = words_per_line * word_width;

    // Address fields, low to high: byte, offset, index, tag
    localparam int byte_sel_bits  = 2;
    localparam int offset_bits    = 2;
    localparam int index_bits     = 8;
    localparam int num_lines      = 1 << index_bits;
    localparam int tag_bits       = addr_width - index_bits - offset_bits - byte_sel_bits;

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    // Processor side uses word addresses
    typedef logic [addr_width-byte_sel_bits-1:0] word_addr_t;

    // Memory side moves whole blocks
    typedef logic [addr_width-byte_sel_bits-offset_bits-1:0] block_addr_t;

    typedef logic [word_width-1:0] word_t;
    typedef logic [word_bytes-1:0] byte_en_t;
    typedef logic [line_width-1:0] line_t;

    // One entry of the tag store
    typedef struct packed {
        logic                valid;
        logic                dirty;
        logic [tag_bits-1:0] tag;
    } tag_entry_t;

    // Controller states
    typedef enum logic [1:0] {
        idle,           // Waiting for a request, also the done cycle
        compare_tag,    // Hit check
        writeback,      // Dirty victim out to memory
        allocate        // Fetch, fill and write merge
    } cache_state_t;

endpackage

// ==== verilog/cache_array.sv ====
`timescale 1ns/100ps

// Register array, read is combinational, write on the clock edge
module cache_array import cache_pkg::*; #(
    parameter type entry_t = line_t,
    parameter int  depth   = num_lines
) (
    input  logic                  clk,
    input  logic                  RESET,
    input  logic [index_bits-1:0] index,
    input  logic                  we,
    input  entry_t                wdata,
    output entry_t                rdata
);

    entry_t mem [depth];

    assign rdata = mem[index];    // Async read

    always_ff @(posedge clk) begin
        if (RESET) begin
            // Clears valid and dirty bits in the tag store
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[index] <= wdata;
        end
    end

endmodule

// ==== verilog/dcache_datapath.sv ====
`timescale 1ns/100ps

module dcache_datapath import cache_pkg::*; (
    input  logic                  clk,
    input  logic                  RESET,
    input  word_addr_t            addr,
    input  word_t                 din,
    input  byte_en_t              be,
    input  logic                  capture_req,
    input  logic                  load_victim,
    input  logic                  load_fill,
    input  logic                  take_fill,
    input  logic                  sel_fill,
    input  logic                  update_word,
    input  logic                  we_req,
    input  tag_entry_t            tag_rd,
    input  line_t                 line_rd,
    input  line_t                 mem_dout,
    output logic                  hit,
    output logic                  victim_dirty,
    output logic [index_bits-1:0] index,
    output tag_entry_t            tag_wr,
    output line_t                 line_wr,
    output word_t                 dout,
    output block_addr_t           mem_baddr,
    output line_t                 mem_din
);

    ////////////////////////////////////////
    // Request address
    ////////////////////////////////////////

    logic [offset_bits-1:0] addr_offset;
    logic [index_bits-1:0]  addr_index;
    logic [tag_bits-1:0]    addr_tag;

    logic [offset_bits-1:0] req_offset;
    logic [index_bits-1:0]  req_index;
    logic [tag_bits-1:0]    req_tag;

    line_t fill_line;     // Block returned by memory
    line_t merged;
    word_t line_word;

    assign addr_offset = addr[offset_bits-1:0];
    assign addr_index  = addr[offset_bits +: index_bits];
    assign addr_tag    = addr[offset_bits+index_bits +: tag_bits];

    assign index = req_index;    // Drives both arrays

    ////////////////////////////////////////
    // Tag check
    ////////////////////////////////////////

    assign hit          = tag_rd.valid && (tag_rd.tag == req_tag);
    assign victim_dirty = tag_rd.valid && tag_rd.dirty;

    // New tag entry, always valid after a write
    always_comb begin
        tag_wr.valid = 1'b1;
        tag_wr.dirty = we_req | (~sel_fill & tag_rd.dirty);    // Fill starts clean
        tag_wr.tag   = req_tag;
    end

    ////////////////////////////////////////
    // Line data
    ////////////////////////////////////////

    // Processor word into the line under byte enables
    always_comb begin
        merged = line_rd;
        for (int b = 0; b < word_bytes; b++) begin
            if (be[b]) begin
                merged[req_offset*word_width + b*8 +: 8] = din[b*8 +: 8];
            end
        end
    end

    assign line_wr   = sel_fill ? fill_line : (update_word ? merged : line_rd);
    assign line_word = line_wr[req_offset*word_width +: word_width];

    always_ff @(posedge clk) begin
        if (RESET) begin
            req_tag    <= '0;
            req_index  <= '0;
            req_offset <= '0;
            dout       <= '0;
        end else begin
            if (capture_req) begin
                req_tag    <= addr_tag;
                req_index  <= addr_index;
                req_offset <= addr_offset;
            end
            // Read result, from a hit or from the fill
            if (!we_req && (hit || sel_fill)) begin
                dout <= line_word;
            end
        end
    end

    ////////////////////////////////////////
    // Memory request fields
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (load_victim) begin
            mem_baddr <= {tag_rd.tag, req_index};    // Victim block address
            mem_din   <= line_rd;
        end else if (load_fill) begin
            mem_baddr <= {req_tag, req_index};
        end
        if (take_fill) begin
            fill_line <= mem_dout;
        end
    end

endmodule

// ==== verilog/dcache_fsm.sv ====
`timescale 1ns/100ps

module dcache_fsm import cache_pkg::*; (
    input  logic clk,
    input  logic RESET,
    input  logic en,
    input  logic we,
    input  logic hit,
    input  logic victim_dirty,
    input  logic mem_hold,
    output logic hold,
    output logic mem_en,
    output logic mem_we,
    output logic tag_we,
    output logic data_we,
    output logic capture_req,
    output logic load_victim,
    output logic load_fill,
    output logic take_fill,
    output logic sel_fill,
    output logic update_word,
    output logic we_req
);

    // Steps inside allocate
    typedef enum logic [1:0] {
        fill_issue,    // Raise mem_en after a writeback
        fill_wait,     // Read outstanding
        fill_write,    // Fetched block into the arrays
        fill_merge     // Write miss only
    } fill_step_t;

    cache_state_t state, next_state;
    fill_step_t   step, next_step;

    logic done, next_done;    // Done cycle, en ignored
    logic next_mem_en;
    logic next_mem_we;
    logic next_we_req;

    ////////////////////////////////////////
    // Next state and strobes
    ////////////////////////////////////////

    always_comb begin
        next_state  = state;
        next_step   = step;
        next_done   = 1'b0;
        next_mem_en = mem_en;
        next_mem_we = mem_we;
        next_we_req = we_req;
        hold        = 1'b1;
        tag_we      = 1'b0;
        data_we     = 1'b0;
        capture_req = 1'b0;
        load_victim = 1'b0;
        load_fill   = 1'b0;
        take_fill   = 1'b0;
        sel_fill    = 1'b0;
        update_word = 1'b0;

        case (state)
            idle: begin
                hold = en & ~done;
                if (en && !done) begin
                    capture_req = 1'b1;
                    next_we_req = we;
                    next_state  = compare_tag;
                end
            end

            compare_tag: begin
                if (hit) begin
                    if (we_req) begin    // Write hit, merge now
                        update_word = 1'b1;
                        data_we     = 1'b1;
                        tag_we      = 1'b1;
                    end
                    next_done  = 1'b1;
                    next_state = idle;
                end else if (victim_dirty) begin
                    load_victim = 1'b1;
                    next_mem_en = 1'b1;
                    next_mem_we = 1'b1;
                    next_state  = writeback;
                end else begin
                    load_fill   = 1'b1;
                    next_mem_en = 1'b1;
                    next_step   = fill_wait;
                    next_state  = allocate;
                end
            end

            writeback: begin
                if (!mem_hold) begin
                    // Block accepted, mem_en low for a cycle
                    load_fill   = 1'b1;
                    next_mem_en = 1'b0;
                    next_mem_we = 1'b0;
                    next_step   = fill_issue;
                    next_state  = allocate;
                end
            end

            allocate: begin
                case (step)
                    fill_issue: begin
                        next_mem_en = 1'b1;
                        next_step   = fill_wait;
                    end
                    fill_wait: begin
                        if (!mem_hold) begin
                            take_fill   = 1'b1;
                            next_mem_en = 1'b0;
                            next_step   = fill_write;
                        end
                    end
                    fill_write: begin
                        sel_fill = 1'b1;
                        data_we  = 1'b1;
                        tag_we   = 1'b1;
                        if (we_req) begin
                            next_step = fill_merge;
                        end else begin
                            next_done  = 1'b1;
                            next_state = idle;
                        end
                    end
                    fill_merge: begin
                        update_word = 1'b1;    // Over the line just filled
                        data_we     = 1'b1;
                        tag_we      = 1'b1;
                        next_done   = 1'b1;
                        next_state  = idle;
                    end
                endcase
            end
        endcase
    end

    ////////////////////////////////////////
    // State registers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (RESET) begin
            state  <= idle;
            step   <= fill_issue;
            done   <= 1'b0;
            mem_en <= 1'b0;
            mem_we <= 1'b0;
            we_req <= 1'b0;
        end else begin
            state  <= next_state;
            step   <= next_step;
            done   <= next_done;
            mem_en <= next_mem_en;
            mem_we <= next_mem_we;
            we_req <= next_we_req;
        end
    end

endmodule

// ==== verilog/dcache.sv ====
`timescale 1ns/100ps

module dcache import cache_pkg::*; (
    input  logic        clk,
    input  logic        RESET,
    // Processor port
    input  logic        en,
    input  logic        we,
    input  word_addr_t  addr,
    input  word_t       din,
    input  byte_en_t    be,
    output word_t       dout,
    output logic        hold,
    // Memory port
    output logic        mem_en,
    output logic        mem_we,
    output block_addr_t mem_baddr,
    output line_t       mem_din,
    input  line_t       mem_dout,
    input  logic        mem_hold
);

    logic hit;
    logic victim_dirty;
    logic tag_we;
    logic data_we;
    logic capture_req;
    logic load_victim;
    logic load_fill;
    logic take_fill;
    logic sel_fill;
    logic update_word;
    logic we_req;

    logic [index_bits-1:0] index;
    tag_entry_t            tag_rd, tag_wr;
    line_t                 line_rd, line_wr;

    dcache_fsm ctrl (
        .clk          (clk),
        .RESET        (RESET),
        .en           (en),
        .we           (we),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .mem_hold     (mem_hold),
        .hold         (hold),
        .mem_en       (mem_en),
        .mem_we       (mem_we),
        .tag_we       (tag_we),
        .data_we      (data_we),
        .capture_req  (capture_req),
        .load_victim  (load_victim),
        .load_fill    (load_fill),
        .take_fill    (take_fill),
        .sel_fill     (sel_fill),
        .update_word  (update_word),
        .we_req       (we_req)
    );

    dcache_datapath dpath (
        .clk          (clk),
        .RESET        (RESET),
        .addr         (addr),
        .din          (din),
        .be           (be),
        .capture_req  (capture_req),
        .load_victim  (load_victim),
        .load_fill    (load_fill),
        .take_fill    (take_fill),
        .sel_fill     (sel_fill),
        .update_word  (update_word),
        .we_req       (we_req),
        .tag_rd       (tag_rd),
        .line_rd      (line_rd),
        .mem_dout     (mem_dout),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .index        (index),
        .tag_wr       (tag_wr),
        .line_wr      (line_wr),
        .dout         (dout),
        .mem_baddr    (mem_baddr),
        .mem_din      (mem_din)
    );

    ////////////////////////////////////////
    // Tag and line stores
    ////////////////////////////////////////

    cache_array #(.entry_t(tag_entry_t), .depth(num_lines)) tag_store (
        .clk   (clk),
        .RESET (RESET),
        .index (index),
        .we    (tag_we),
        .wdata (tag_wr),
        .rdata (tag_rd)
    );

    cache_array #(.entry_t(line_t), .depth(num_lines)) line_store (
        .clk   (clk),
        .RESET (RESET),
        .index (index),
        .we    (data_we),
        .wdata (line_wr),
        .rdata (line_rd)
    );

endmodule

// ==== test/tb_mem_model.sv ====
`timescale 1ns/100ps

// Block memory behind the cache, holds each transfer for a random number of cycles
module tb_mem_model import cache_pkg::*; #(
    parameter word_t fill_key = 32'h0
) (
    input  logic        clk,
    input  logic        RESET,
    input  logic        mem_en,
    input  logic        mem_we,
    input  block_addr_t mem_baddr,
    input  line_t       mem_din,
    input  logic [2:0]  stall_len,    // Hold length for the next transfer
    output line_t       mem_dout,
    output logic        mem_hold
);

    line_t       blocks [4096];
    logic [2:0]  wait_cnt;
    logic [11:0] blk;

    // Every word starts as its own word address with the key mixed in
    initial begin
        for (int b = 0; b < 4096; b++) begin
            for (int w = 0; w < words_per_line; w++) begin
                blocks[b][w*word_width +: word_width] = word_t'(b*words_per_line + w) ^ fill_key;
            end
        end
    end

    assign blk      = mem_baddr[11:0];
    assign mem_dout = blocks[blk];
    assign mem_hold = mem_en && (wait_cnt != 3'd0);

    ////////////////////////////////////////
    // Transfer completion
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (RESET) begin
            wait_cnt <= 3'd0;
        end else if (mem_en) begin
            if (wait_cnt != 3'd0) begin
                wait_cnt <= wait_cnt - 3'd1;
            end else begin
                if (mem_we) begin
                    blocks[blk] <= mem_din;    // Writeback lands here
                end
                wait_cnt <= stall_len;
            end
        end
    end

endmodule

// ==== test/tb_dcache.sv ====
`timescale 1ns/100ps

module tb_dcache import cache_pkg::*; ();

    localparam word_t fill_key   = 32'h3C96_0000;
    localparam int    done_limit = 100;    // Cycles before a wait gives up

    logic        clk;
    logic        RESET;
    logic        en;
    logic        we;
    word_addr_t  addr;
    word_t       din;
    byte_en_t    be;
    word_t       dout;
    logic        hold;
    logic        mem_en;
    logic        mem_we;
    block_addr_t mem_baddr;
    line_t       mem_din;
    line_t       mem_dout;
    logic        mem_hold;
    logic [2:0]  stall_len = '0;

    word_t       shadow [4096];    // Tags 0 to 3 keep word addresses below 4096
    logic [31:0] stim_lfsr;
    logic [31:0] stall_lfsr = 32'd32355;
    word_t       exp_word;
    string       exp_name;
    int          reads_issued;
    int          reads_checked;
    int          word_checks;
    int          word_errors;
    int          line_checks;
    int          line_errors;
    int          other_errors;
    int          wb_count;
    block_addr_t wb_baddr;
    line_t       wb_data;

    dcache DUT (
        .clk       (clk),
        .RESET     (RESET),
        .en        (en),
        .we        (we),
        .addr      (addr),
        .din       (din),
        .be        (be),
        .dout      (dout),
        .hold      (hold),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_baddr (mem_baddr),
        .mem_din   (mem_din),
        .mem_dout  (mem_dout),
        .mem_hold  (mem_hold)
    );

    tb_mem_model #(.fill_key(fill_key)) memory (
        .clk       (clk),
        .RESET     (RESET),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_baddr (mem_baddr),
        .mem_din   (mem_din),
        .stall_len (stall_len),
        .mem_dout  (mem_dout),
        .mem_hold  (mem_hold)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////
    // Random numbers and reference
    ////////////////////////////////////////

    // Galois LFSR with x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], stim_lfsr[0]};
            stim_lfsr = lfsr_step(stim_lfsr);
        end
    endtask

    // Memory takes a fresh hold length when a transfer ends
    always @(posedge clk) begin
        logic [2:0] s;
        for (int i = 0; i < 3; i++) begin
            s = {s[1:0], stall_lfsr[0]};
            stall_lfsr = lfsr_step(stall_lfsr);
        end
        stall_len <= s;
    end

    // Applies a write to the shadow words and returns the word as it reads afterwards
    function automatic word_t ref_access(input logic wr, input word_addr_t a,
                                         input word_t d, input byte_en_t b);
        word_t w;
        w = shadow[a[11:0]];
        if (wr) begin
            for (int i = 0; i < word_bytes; i++) begin
                if (b[i]) begin
                    w[i*8 +: 8] = d[i*8 +: 8];
                end
            end
            shadow[a[11:0]] = w;
        end
        return w;
    endfunction

    function automatic line_t ref_block(input block_addr_t ba);
        line_t       l;
        logic [11:0] wa;
        for (int w = 0; w < words_per_line; w++) begin
            wa = {ba[9:0], 2'(w)};
            l[w*word_width +: word_width] = shadow[wa];    // Word 0 in the low bits
        end
        return l;
    endfunction

    function automatic word_addr_t word_addr(input logic [1:0] tag, input logic [7:0] index,
                                             input logic [1:0] offset);
        return {18'd0, tag, index, offset};
    endfunction

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        word_checks++;
        if (actual !== expected) begin
            word_errors++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_line(input string name, input line_t expected, input line_t actual);
        line_checks++;
        if (actual !== expected) begin
            line_errors++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_baddr(input string name, input block_addr_t expected,
                               input block_addr_t actual);
        if (actual !== expected) begin
            other_errors++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Read data compared in the done cycle
    always @(negedge clk) begin
        if (reads_checked != reads_issued && !hold) begin
            check_word(exp_name, exp_word, dout);
            reads_checked <= reads_checked + 1;
        end
    end

    // Each completed writeback transfer
    always @(negedge clk) begin
        if (mem_en && mem_we && !mem_hold) begin
            wb_count <= wb_count + 1;
            wb_baddr <= mem_baddr;
            wb_data  <= mem_din;
        end
    end

    task automatic expect_latency(input string name, input int cycles, input int expected);
        if (cycles != expected) begin
            other_errors++;
            $display("FAIL %s latency: expected %0d, actual %0d", name, expected, cycles);
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d of %0d reads, %0d of %0d blocks, %0d other",
                 word_errors, word_checks, line_errors, line_checks, other_errors);
        if (word_errors + line_errors + other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    ////////////////////////////////////////
    // Processor requests
    ////////////////////////////////////////

    // Counts cycles with hold high until the done cycle
    task automatic wait_done(output int cycles);
        int n;
        n = 0;
        @(negedge clk);
        while (hold && n < done_limit) begin
            n++;
            @(negedge clk);
        end
        cycles = n;
        if (hold) begin
            other_errors++;
            $display("Request not finished, hold still high after %0d cycles", done_limit);
            finish_run();
        end
    endtask

    task automatic access(input string name, input logic wr, input word_addr_t a,
                          input word_t d, input byte_en_t b, output int cycles);
        word_t expected;
        expected = ref_access(wr, a, d, b);
        @(posedge clk);
        en   <= 1'b1;
        we   <= wr;
        addr <= a;
        din  <= d;
        be   <= b;
        if (!wr) begin
            exp_word = expected;
            exp_name = name;
            reads_issued++;
        end
        wait_done(cycles);
    endtask

    initial begin
        int          cycles;
        int          wb_before;
        logic [31:0] r;
        logic        wr;
        byte_en_t    ben;
        word_addr_t  a;

        stim_lfsr = 32'd32355;
        for (int i = 0; i < 4096; i++) begin
            shadow[i] = word_t'(i) ^ fill_key;
        end
        RESET = 1'b1;
        en    = 1'b0;
        we    = 1'b0;
        addr  = '0;
        din   = '0;
        be    = '0;
        repeat (16) @(posedge clk);
        RESET <= 1'b0;

        repeat (2) @(negedge clk);
        if (mem_en !== 1'b0 || hold !== 1'b0) begin
            other_errors++;
            $display("mem_en or hold is not low after reset while en is low");
        end

        // Clean miss then hits on the same word
        a = word_addr(2'd0, 8'h10, 2'd2);
        access("read miss", 1'b0, a, '0, '0, cycles);
        access("write hit", 1'b1, a, 32'h1122_3344, 4'b0101, cycles);
        expect_latency("write hit", cycles, 2);
        access("read hit", 1'b0, a, '0, '0, cycles);
        expect_latency("read hit", cycles, 2);

        a = word_addr(2'd3, 8'h20, 2'd0);
        access("write miss", 1'b1, a, 32'h5A6B_7C8D, 4'b1110, cycles);
        access("read after write miss", 1'b0, a, '0, '0, cycles);

        ////////////////////////////////////////
        // Dirty victim
        ////////////////////////////////////////

        a = word_addr(2'd1, 8'h40, 2'd1);
        access("dirty line write", 1'b1, a, 32'h0F1E_2D3C, 4'b1111, cycles);
        wb_before = wb_count;
        access("conflict read", 1'b0, word_addr(2'd2, 8'h40, 2'd3), '0, '0, cycles);
        if (wb_count != wb_before + 1) begin
            other_errors++;
            $display("Dirty block %h was not written back exactly once", a[29:2]);
        end
        check_baddr("writeback address", a[29:2], wb_baddr);
        check_line("writeback block", ref_block(a[29:2]), wb_data);
        access("read after writeback", 1'b0, a, '0, '0, cycles);

        // Few tags and indexes so lines conflict often
        for (int n = 0; n < 300; n++) begin
            draw_bits(1, r);
            wr = r[0];
            draw_bits(7, r);
            a = word_addr(r[6:5], {5'd0, r[4:2]}, r[1:0]);
            draw_bits(4, r);
            ben = r[3:0];
            draw_bits(32, r);
            access("random access", wr, a, r, ben, cycles);
        end

        @(posedge clk);
        en <= 1'b0;
        repeat (4) @(posedge clk);
        finish_run();
    end

endmodule

// ==== filelist.f ====
verilog/cache_pkg.sv
verilog/cache_array.sv
verilog/dcache_datapath.sv
verilog/dcache_fsm.sv
verilog/dcache.sv
test/tb_mem_model.sv
test/tb_dcache.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build the data cache testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --timescale 1ns/100ps --top-module tb_dcache \
        -f filelist.f -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vtb_dcache > "$log" 2>&1; then
    cat "$log"
    echo "Simulation exited with an error status"
    exit 1
fi

cat "$log"

if grep -q "Done: errors found" "$log"; then
    exit 1
fi
exit 0
